// ==== tb.f ====
hw/analog_pkg.sv
hw/adc_frontend.sv
hw/dac_mixer.sv
hw/dac_interleaver.sv
hw/analog_top.sv
tb/analog_assertions.sv
tb/tb_analog_top.sv

// ==== Makefile ====
# Verilator build and run for the analog datapath testbench
# override any variable on the command line, e.g. make run BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_analog_top
FILELIST  ?= tb.f
BUILD_DIR ?= obj_dir
VFLAGS    ?=
RUN_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= Simulation passed

SIM_BIN   := $(BUILD_DIR)/V$(TOP)
SOURCES   := $(shell cat $(FILELIST))

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary --timing --assert \
	  --top-module $(TOP) -Mdir $(BUILD_DIR) \
	  -f $(FILELIST) $(VFLAGS)

# status comes from the pass line, not from the simulator exit code
run: compile
	@out="$$($(SIM_BIN) $(RUN_ARGS))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// ==== tb/tb_analog_top.sv ====
module tb_analog_top;

  import analog_pkg::*;

  localparam int CH       = CH_N_DEF;  // DAC side is fixed at two
  localparam int HALF     = 50;        // half clock period
  localparam int HOLD     = 6;         // cycles each vector is held
  localparam int N_VEC    = 8;         // vectors per test
  localparam int VEC_TMO  = 40;        // compare side, cycles without a vector
  localparam int RST_TMO  = 20;        // cycles until reset release
  localparam int SEL_TMO  = 3;         // cycles until a sel high word
  localparam int DONE_TMO = 20;        // drive side, cycles until compared

  // kind of the current vector, tells the compare process what to look at
  localparam int M_RESET = 0;
  localparam int M_ADC   = 1;
  localparam int M_SUM   = 2;
  localparam int M_SAT   = 3;
  localparam int M_LOOP  = 4;

  logic              adc_clk;
  logic              top_rst;
  adc_raw_t [CH-1:0] adc_dat;       // ADC pins
  sample_t  [CH-1:0] gen_dat;       // generator stream
  sample_t  [CH-1:0] ctl_dat;       // controller stream
  logic              digital_loop;
  sample_t  [CH-1:0] adc_dat_out;   // captured samples
  dac_bus_t          dac_bus;       // DAC pins

  logic [31:0] lfsr;                // random state
  int          mode;                // what the held vector tests
  int          vec_cnt;             // vectors issued
  int          checked_cnt;         // vectors compared
  int          seen;                // last vector the compare side picked up
  int          err_cnt;
  int          check_cnt;
  sample_t     exp_adc [CH];        // expected adc_dat_o
  dac_code_t   exp_code [CH];       // expected DAC codes

  //////////////////////////////////////////////////////////////////////
  // clock and DUT
  //////////////////////////////////////////////////////////////////////

  initial begin
    adc_clk = 1'b0;
    forever #HALF adc_clk = ~adc_clk;
  end

  analog_top #(
    .CH_N           (CH)
  ) DUT (
    .adc_clk        (adc_clk     ),
    .top_rst        (top_rst     ),
    .adc_dat_i      (adc_dat     ),
    .gen_dat_i      (gen_dat     ),
    .ctl_dat_i      (ctl_dat     ),
    .digital_loop_i (digital_loop),
    .adc_dat_o      (adc_dat_out ),
    .dac_o          (dac_bus     )
  );

  //////////////////////////////////////////////////////////////////////
  // random numbers and reference model
  //////////////////////////////////////////////////////////////////////

  // fibonacci, taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_bits(input int n, output logic [31:0] v);
    int i;
    v = '0;
    for (i = 0; i < n; i++) begin
      lfsr = lfsr_step(lfsr);
      v    = {v[30:0], lfsr[0]};  // one step per bit
    end
  endtask

  // sum clamped to the 14 bit range
  function automatic sample_t ref_sum(input sample_t a, input sample_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191) begin
      s = 8191;
    end else if (s < -8192) begin
      s = -8192;
    end
    return sample_t'(s);
  endfunction

  // negative slope offset binary, code 8191 sits at zero
  function automatic dac_code_t ref_dac_code(input sample_t v);
    return dac_code_t'(8191 - int'(v));
  endfunction

  // upper 14 pin bits hold the code, the rest is reserved
  function automatic sample_t ref_adc(input adc_raw_t raw);
    return sample_t'(8191 - int'(raw[ADC_RAW_W-1:2]));
  endfunction

  //////////////////////////////////////////////////////////////////////
  // compare process
  //////////////////////////////////////////////////////////////////////

  task automatic check_val(input string what, input int got, input int want);
    check_cnt++;
    assert (got == want) else begin
      err_cnt++;
      $display("[ERROR] %0t %s: got %0d, expected %0d", $time, what, got, want);
    end
  endtask

  // mid high phase, all flops and inputs settled
  task automatic next_sample();
    @(posedge adc_clk);
    #(HALF / 2);
  endtask

  task automatic wait_vector(output bit ok);
    int n;
    n = 0;
    next_sample();
    while (vec_cnt == seen && n < VEC_TMO) begin
      next_sample();
      n++;
    end
    ok   = (vec_cnt != seen);
    seen = vec_cnt;
  endtask

  initial begin : compare_outputs
    bit ok;
    int n;
    int ch;
    seen        = 0;
    checked_cnt = 0;
    ok          = 1'b1;
    while (ok) begin
      wait_vector(ok);
      if (!ok) begin
        err_cnt++;
        $display("timeout: no new vector reached the compare process");
      end else begin
        case (mode)
          M_RESET: begin
            check_val("reset dac rst", int'(dac_bus.rst), 1);
            check_val("reset dac sel", int'(dac_bus.sel), 0);
            check_val("reset dac wrt", int'(dac_bus.wrt), 0);
            check_val("reset dac dat", int'(dac_bus.dat), 0);
            for (ch = 0; ch < CH; ch++) begin
              check_val($sformatf("reset adc ch%0d", ch), int'(adc_dat_out[ch]), 0);
            end
            n = 0;
            while (top_rst && n < RST_TMO) begin
              next_sample();
              n++;
            end
            if (top_rst) begin
              err_cnt++;
              $display("timeout: reset was never released");
            end else begin
              check_val("release dac rst", int'(dac_bus.rst), 0);  // first edge out
              check_val("release dac wrt", int'(dac_bus.wrt), 1);
            end
          end
          M_ADC, M_LOOP: begin
            // capture or loopback shows up one edge after the drive
            for (ch = 0; ch < CH; ch++) begin
              check_val($sformatf("adc ch%0d", ch), int'(adc_dat_out[ch]),
                        int'(exp_adc[ch]));
            end
          end
          M_SUM, M_SAT: begin
            next_sample();  // mixer register, then the interleaver
            n = 0;
            while (!dac_bus.sel && n < SEL_TMO) begin
              next_sample();
              n++;
            end
            if (!dac_bus.sel) begin
              err_cnt++;
              $display("timeout: DAC never showed a channel 1 word");
            end else begin
              check_val("dac ch1 code", int'(dac_bus.dat), int'(exp_code[1]));
              next_sample();
              check_val("dac sel low", int'(dac_bus.sel), 0);
              check_val("dac ch0 code", int'(dac_bus.dat), int'(exp_code[0]));
              check_val("dac wrt", int'(dac_bus.wrt), 1);
            end
          end
          default: begin
            err_cnt++;
            $display("unknown vector kind %0d", mode);
          end
        endcase
        checked_cnt = seen;
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic wait_checked();
    int n;
    n = 0;
    while (checked_cnt != vec_cnt && n < DONE_TMO) begin
      @(negedge adc_clk);
      n++;
    end
    if (checked_cnt != vec_cnt) begin
      err_cnt++;
      $display("timeout: compare process stalled on vector %0d", vec_cnt);
    end
  endtask

  task automatic print_test(input string name, input int e0, input int c0);
    $display("test %0s: %0d checks, %0d errors", name, check_cnt - c0, err_cnt - e0);
  endtask

  // one test, N_VEC vectors of one kind, driven on falling edges
  task automatic run_test(input string name, input int kind);
    logic [31:0] r;
    sample_t     g;
    sample_t     c;
    int          e0;
    int          c0;
    int          v;
    int          ch;
    e0           = err_cnt;
    c0           = check_cnt;
    digital_loop = (kind == M_LOOP);
    for (v = 0; v < N_VEC; v++) begin
      for (ch = 0; ch < CH; ch++) begin
        draw_bits(16, r);
        adc_dat[ch] = r[15:0];  // reserved bits random too
        exp_adc[ch] = ref_adc(r[15:0]);
        if (kind == M_SUM) begin
          draw_bits(13, r);
          g = {r[12], r[12:0]};  // half range, sum always fits
          draw_bits(13, r);
          c = {r[12], r[12:0]};
        end else if (kind == M_SAT) begin
          draw_bits(12, r);
          g = v[0] ? {2'b10, r[11:0]} : {2'b01, r[11:0]};  // same sign, large
          draw_bits(12, r);
          c = v[0] ? {2'b10, r[11:0]} : {2'b01, r[11:0]};
        end else begin
          draw_bits(14, r);
          g = r[13:0];
          draw_bits(14, r);
          c = r[13:0];
        end
        gen_dat[ch]  = g;
        ctl_dat[ch]  = c;
        exp_code[ch] = ref_dac_code(ref_sum(g, c));
        if (kind == M_LOOP) begin
          exp_adc[ch] = ref_sum(g, c);  // pins ignored
        end
      end
      mode = kind;
      vec_cnt++;
      repeat (HOLD) @(negedge adc_clk);
    end
    wait_checked();
    print_test(name, e0, c0);
  endtask

  initial begin : drive_inputs
    int e0;
    int c0;
    int ch;
    lfsr         = 32'hb1c5_d624;
    top_rst      = 1'b1;
    adc_dat      = '0;
    gen_dat      = '0;
    ctl_dat      = '0;
    digital_loop = 1'b0;
    err_cnt      = 0;
    check_cnt    = 0;
    vec_cnt      = 0;
    mode         = M_RESET;
    for (ch = 0; ch < CH; ch++) begin
      exp_adc[ch]  = '0;
      exp_code[ch] = '0;
    end
    e0      = 0;
    c0      = 0;
    vec_cnt = 1;  // reset check runs while reset is held
    repeat (8) @(negedge adc_clk);
    top_rst = 1'b0;
    wait_checked();
    print_test("reset", e0, c0);
    run_test("adc_conversion", M_ADC);
    run_test("summation", M_SUM);
    run_test("saturation", M_SAT);
    run_test("loopback", M_LOOP);
    err_cnt += DUT.i_dac_interleaver.i_analog_assertions.fail_cnt;
    $display("tests 5, checks %0d, assertion failures %0d, errors %0d",
             check_cnt, DUT.i_dac_interleaver.i_analog_assertions.fail_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

// ==== tb/analog_assertions.sv ====
module analog_assertions (
  input logic                 adc_clk,  // ADC clock
  input logic                 top_rst,  // async reset, active high
  input analog_pkg::dac_bus_t dac_o     // DAC pins
);

  int fail_cnt = 0;  // read by the testbench at the end

  //////////////////////////////////////////////////////////////////////
  // DAC pin protocol
  //////////////////////////////////////////////////////////////////////

  // channel select flips on every edge once running
  sel_toggle: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> dac_o.sel != $past(dac_o.sel)
  ) else begin
    fail_cnt++;
    $error("DAC sel held its level for two cycles");
  end

  // write strobe never drops outside reset
  wrt_high: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> dac_o.wrt
  ) else begin
    fail_cnt++;
    $error("DAC wrt low after reset");
  end

  // DAC reset released one edge after top_rst
  rst_low: assert property (
    @(posedge adc_clk) disable iff (top_rst)
    !$past(top_rst) |-> !dac_o.rst
  ) else begin
    fail_cnt++;
    $error("DAC rst still high after reset release");
  end

endmodule

bind dac_interleaver analog_assertions i_analog_assertions (
  .adc_clk (adc_clk),
  .top_rst (top_rst),
  .dac_o   (dac_o  )
);

// ==== hw/analog_top.sv ====
module analog_top #(
  parameter int unsigned CH_N = analog_pkg::CH_N_DEF  // channel count
)(
  // clock and reset
  input  logic                            adc_clk,         // ADC clock
  input  logic                            top_rst,         // async reset, active high
  // ADC
  input  analog_pkg::adc_raw_t [CH_N-1:0] adc_dat_i,       // ADC pin words
  // generate side
  input  analog_pkg::sample_t  [CH_N-1:0] gen_dat_i,       // generator stream
  input  analog_pkg::sample_t  [CH_N-1:0] ctl_dat_i,       // controller stream
  // configuration
  input  logic                            digital_loop_i,  // DAC -> ADC loopback
  // acquire side
  output analog_pkg::sample_t  [CH_N-1:0] adc_dat_o,       // captured samples
  // DAC
  output analog_pkg::dac_bus_t            dac_o            // DAC pins
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // local signals
  //////////////////////////////////////////////////////////////////////

  sample_t [CH_N-1:0] acq_dat;  // ADC samples or loopback
  sample_t [CH_N-1:0] dac_sat;  // saturated sums, to DAC and loopback

  //////////////////////////////////////////////////////////////////////
  // ADC input side
  //////////////////////////////////////////////////////////////////////

  adc_frontend #(
    .CH_N           (CH_N)
  ) i_adc_frontend (
    .adc_clk        (adc_clk       ),
    .top_rst        (top_rst       ),
    .adc_dat_i      (adc_dat_i     ),
    .loop_dat_i     (dac_sat       ),  // looped back before DAC coding
    .digital_loop_i (digital_loop_i),
    .acq_dat_o      (acq_dat       )
  );

  assign adc_dat_o = acq_dat;  // stands in for the scope input

  //////////////////////////////////////////////////////////////////////
  // summation and saturation
  //////////////////////////////////////////////////////////////////////

  dac_mixer #(
    .CH_N      (CH_N)
  ) i_dac_mixer (
    .adc_clk   (adc_clk  ),
    .top_rst   (top_rst  ),
    .gen_dat_i (gen_dat_i),
    .ctl_dat_i (ctl_dat_i),
    .sat_dat_o (dac_sat  )
  );

  //////////////////////////////////////////////////////////////////////
  // DAC output side
  //////////////////////////////////////////////////////////////////////

  // the DAC has two channels, only the lowest pair goes out
  dac_interleaver i_dac_interleaver (
    .adc_clk   (adc_clk     ),
    .top_rst   (top_rst     ),
    .sat_dat_i (dac_sat[1:0]),
    .dac_o     (dac_o       )
  );

endmodule

// ==== hw/dac_interleaver.sv ====
module dac_interleaver (
  input  logic                   adc_clk,    // ADC clock
  input  logic                   top_rst,    // async reset, active high
  input  analog_pkg::sample_t [1:0] sat_dat_i,  // saturated pair, ch 1 and ch 0
  output analog_pkg::dac_bus_t   dac_o       // DAC pins
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // code conversion
  //////////////////////////////////////////////////////////////////////

  // two's complement -> negative slope offset binary
  // same bit flip as on the ADC side, msb kept
  function automatic dac_code_t to_dac_code(input sample_t smp);
    dac_code_t code;
    code = {smp[SAMPLE_W-1], ~smp[SAMPLE_W-2:0]};
    return code;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // phase and pair hold
  //////////////////////////////////////////////////////////////////////

  logic     phase;  // 0: next edge takes a fresh pair
  sample_t  ch0_q;  // ch 0 waits one cycle behind ch 1
  sample_t  pick;   // sample going out on the next edge
  dac_bus_t bus_q;  // registered pin state

  // half rate toggle, replaces the DDR output stage
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      phase <= 1'b0;
    end else begin
      phase <= ~phase;
    end
  end

  // latch the pair on a phase 0 edge
  // ch 1 goes out right away, only ch 0 needs holding
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      ch0_q <= '0;
    end else if (!phase) begin
      ch0_q <= sat_dat_i[0];
    end
  end

  // phase 0 -> ch 1 from the live pair
  // phase 1 -> ch 0 from the hold register
  assign pick = phase ? ch0_q : sat_dat_i[1];

  //////////////////////////////////////////////////////////////////////
  // output register and strobes
  //////////////////////////////////////////////////////////////////////

  // everything on the pins comes straight from flops
  always_ff @(posedge adc_clk, posedge top_rst) begin
    if (top_rst) begin
      bus_q     <= '0;
      bus_q.rst <= 1'b1;  // DAC held in reset
    end else begin
      bus_q.rst <= 1'b0;                // falls on first edge after release
      bus_q.wrt <= 1'b1;                // write every cycle
      bus_q.sel <= ~phase;              // high with ch 1 data
      bus_q.dat <= to_dac_code(pick);
    end
  end

  assign dac_o = bus_q;

  // resulting pin sequence after release
  //   edge 1: rst 0, wrt 1, sel 1, ch 1 of pair n
  //   edge 2: rst 0, wrt 1, sel 0, ch 0 of pair n
  //   edge 3: sel 1, ch 1 of pair n+1 ...
  // mixer input to pins is 2 cycles for ch 1, 3 for ch 0,
  // or one more when the pair misses a phase 0 edge

endmodule

// ==== hw/dac_mixer.sv ====
module dac_mixer #(
  parameter int unsigned CH_N = analog_pkg::CH_N_DEF  // channel count
)(
  input  logic                           adc_clk,    // ADC clock
  input  logic                           top_rst,    // async reset, active high
  input  analog_pkg::sample_t [CH_N-1:0] gen_dat_i,  // generator samples
  input  analog_pkg::sample_t [CH_N-1:0] ctl_dat_i,  // controller samples
  output analog_pkg::sample_t [CH_N-1:0] sat_dat_o   // saturated sums
);

  import analog_pkg::*;

  localparam int unsigned SUM_W = SAMPLE_W + 1;  // one guard bit

  // limits, for reference
  //   most positive  8191 = 0_1_1111_1111_1111
  //   most negative -8192 = 1_0_0000_0000_0000
  // the clamp value is just the sign bit followed by its inverse

  //////////////////////////////////////////////////////////////////////
  // per channel sum and saturation
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CH_N; i++) begin : g_ch

    logic signed [SUM_W-1:0] sum;    // full precision sum
    logic                    ovf;    // sum left the 14 bit range
    sample_t                 sat;    // clamped sum
    sample_t                 sat_q;  // output register

    // sign extended add, never overflows in 15 bits
    assign sum = SUM_W'(gen_dat_i[i]) + SUM_W'(ctl_dat_i[i]);

    // top two bits differ -> result does not fit in 14 bits
    assign ovf = sum[SUM_W-1] ^ sum[SUM_W-2];

    // clamp towards the sign of the true sum
    always_comb begin
      if (ovf) begin
        sat = {sum[SUM_W-1], {(SAMPLE_W-1){~sum[SUM_W-1]}}};  // 8191 or -8192
      end else begin
        sat = sum[SAMPLE_W-1:0];  // drop guard bit, value unchanged
      end
    end

    // register, dac_sat is one cycle behind the inputs
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        sat_q <= '0;
      end else begin
        sat_q <= sat;
      end
    end

    assign sat_dat_o[i] = sat_q;

  end : g_ch

  // the registered sum feeds both the DAC interleaver and the
  // ADC loopback path, so the loopback sees exactly what the DAC gets

endmodule

// ==== hw/adc_frontend.sv ====
module adc_frontend #(
  parameter int unsigned CH_N = analog_pkg::CH_N_DEF  // channel count
)(
  input  logic                            adc_clk,         // ADC clock
  input  logic                            top_rst,         // async reset, active high
  input  analog_pkg::adc_raw_t [CH_N-1:0] adc_dat_i,       // ADC pin words
  input  analog_pkg::sample_t  [CH_N-1:0] loop_dat_i,      // saturated DAC samples
  input  logic                            digital_loop_i,  // loopback enable
  output analog_pkg::sample_t  [CH_N-1:0] acq_dat_o        // samples to acquisition
);

  import analog_pkg::*;

  //////////////////////////////////////////////////////////////////////
  // format conversion
  //////////////////////////////////////////////////////////////////////

  // negative slope offset binary -> two's complement
  // sign bit passes, the 13 data bits flip
  // the two lowest pin bits are reserved and never reach the sample
  function automatic sample_t adc_to_sample(input adc_raw_t raw);
    sample_t smp;
    smp = {raw[ADC_RAW_W-1], ~raw[ADC_RAW_W-2:ADC_RAW_W-SAMPLE_W]};
    return smp;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // per channel capture and loopback
  //////////////////////////////////////////////////////////////////////

  for (genvar i = 0; i < CH_N; i++) begin : g_ch

    sample_t adc_q;  // captured, already converted

    // input register
    // conversion sits in front of the flop so the reset value
    // reads as a zero sample, not as mid scale code
    always_ff @(posedge adc_clk, posedge top_rst) begin
      if (top_rst) begin
        adc_q <= '0;
      end else begin
        adc_q <= adc_to_sample(adc_dat_i[i]);  // one cycle capture
      end
    end

    // digital loopback multiplexer
    // combinational on purpose, loop data is already registered
    // in the mixer
    assign acq_dat_o[i] = digital_loop_i ? loop_dat_i[i]  // DAC side
                                         : adc_q;         // ADC side

  end : g_ch

  // note: loop_dat_i is the saturated sum, before the DAC code
  // conversion, so both sources share one number format here

endmodule

// ==== hw/analog_pkg.sv ====
package analog_pkg;

  //////////////////////////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned SAMPLE_W  = 14;  // processed sample width
  localparam int unsigned ADC_RAW_W = 16;  // ADC pin word, two lsb reserved
  localparam int unsigned CH_N_DEF  = 2;   // board has two channels

  //////////////////////////////////////////////////////////////////////
  // sample types
  //////////////////////////////////////////////////////////////////////

  // two's complement, as used by generator and controller
  typedef logic signed [SAMPLE_W-1:0] sample_t;

  // raw word straight from the ADC pins
  // negative slope offset binary in the upper 14 bits
  typedef logic [ADC_RAW_W-1:0] adc_raw_t;

  // DAC code, negative slope offset binary
  // msb kept, lower bits inverted against sample_t
  typedef logic [SAMPLE_W-1:0] dac_code_t;

  //////////////////////////////////////////////////////////////////////
  // DAC pins
  //////////////////////////////////////////////////////////////////////

  // one interleaved word stream, both channels share dat
  typedef struct packed {
    logic      rst;  // DAC reset, active high
    logic      sel;  // channel select, high for ch 1
    logic      wrt;  // write strobe
    dac_code_t dat;  // data code
  } dac_bus_t;

  // full bus is 17 bits
  // rst on top so a raw dump reads as rst/sel/wrt/dat

endpackage
